// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = des_search_tb
FILELIST  = des_search_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status follows the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== des_search_top.f ====
verilog/des_pkg.sv
verilog/search_pkg.sv
verilog/message_counter_partial.sv
verilog/des_round_engine.sv
verilog/match_reporter.sv
verilog/des_search_top.sv
sim/des_search_tb.sv

// ==== sim/des_search_tb.sv ====
module des_search_tb;

    localparam int              region_bits   = 16;
    localparam longint unsigned count_last    = 32;
    localparam int              max_credits   = 4;
    localparam int              total_results = int'(count_last) + 1;
    localparam int              num_rows      = 3;
    localparam longint          watchdog_limit = longint'(num_rows) * (count_last + 1) * 17 * 8 * 4;

    typedef struct packed {
        des_pkg::des_key_t      key;
        logic [region_bits-1:0] region;
        logic [63:0]            target;
        logic                   rand_pause;   // Toggle host pause at random
        logic                   rand_credit;  // Return credits after a random delay
        logic                   withhold;     // Hold all credits until output stalls
        logic                   restart;      // Sweep a decoy region first, abort it
        int                     match_count;  // Count that hits the target, -1 for none
        logic                   c0_known;
        logic [63:0]            c0;           // Cipher of count 0
    } row_t;

    logic clk, rst_n, start, reset_counter;
    logic pause = 1'b0;
    logic credit_return = 1'b0;
    logic [region_bits-1:0] region_select;
    des_pkg::des_key_t      key;
    logic [63:0]            target;
    search_pkg::result_t    result;
    logic                   result_valid, search_done;

    row_t                stim [num_rows];
    search_pkg::result_t res_q [$];            // Results seen at the host port
    logic [31:0] rng_state = 32'hf063_e16e;
    logic [region_bits-1:0] cur_region = '0;
    logic pause_rand = 1'b0, credit_rand = 1'b0, hold_credits = 1'b0, row_active = 1'b0;
    int owed = 0, total_sent = 0, total_returned = 0, row_results = 0, region_results = 0;
    int message_errors = 0, cipher_errors = 0, flag_errors = 0, other_errors = 0, checked = 0;

    des_search_top #(
        .region_bits (region_bits),
        .count_last  (count_last),
        .max_credits (max_credits)
    ) des_search_top_i (
        .clk (clk), .rst_n (rst_n), .start (start), .pause (pause),
        .reset_counter (reset_counter), .region_select (region_select),
        .key (key), .target (target), .credit_return (credit_return),
        .result (result), .result_valid (result_valid), .search_done (search_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdog_limit);
        $display("Timeout: run still going after %0d time units", watchdog_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Region on top, count in the low bits
    function automatic des_pkg::des_block_u make_block(input logic [region_bits-1:0] region,
                                                       input int count);
        des_pkg::des_block_u b;
        b.msg = {region, (64 - region_bits)'(count)};
        return b;
    endfunction

    task automatic check_message(input des_pkg::des_block_u got, input des_pkg::des_block_u exp,
                                 input string what);
        if (got.msg !== exp.msg) begin
            message_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got.msg, exp.msg);
        end
    endtask

    task automatic check_cipher(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            cipher_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Host side: pause pattern and credit returns, all on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            rng_state     = xorshift32(rng_state);
            pause         = pause_rand && (rng_state[2:0] < 3'd3);
            credit_return = 1'b0;
            if (!hold_credits && owed > 0 && (!credit_rand || rng_state[9:8] == 2'b00)) begin
                credit_return = 1'b1;
                owed--;
            end
        end
    end

    // Output monitor, credit rule and early search_done
    always @(posedge clk) begin
        if (rst_n) begin
            if (row_active && search_done && region_results < total_results) begin
                other_errors++;
                $display("search_done high at %0t before the last result was sent", $time);
            end
            if (result_valid) begin
                res_q.push_back(result);
                total_sent++;
                row_results++;
                owed++;
                if (result.message.msg[63 -: region_bits] == cur_region)
                    region_results++;
                if (total_sent > max_credits + total_returned) begin
                    other_errors++;
                    $display("Result %0d sent at %0t without a credit", total_sent, $time);
                end
                if (search_done) begin
                    other_errors++;
                    $display("search_done high at %0t while a result went out", $time);
                end
            end
            if (credit_return)
                total_returned++;
        end
    end

    task automatic wait_results(input int n);
        while (row_results < n)
            @(negedge clk);
    endtask

    task automatic take_result(output search_pkg::result_t r);
        while (res_q.size() == 0)
            @(negedge clk);
        r = res_q.pop_front();
    endtask

    task automatic run_row(input int idx, input row_t row);
        search_pkg::result_t    r;
        logic [region_bits-1:0] decoy;
        int                     got;
        int                     decoy_next;
        decoy      = row.region ^ 16'h5aa5;
        got        = 0;
        decoy_next = 0;
        @(negedge clk);
        key           = row.key;
        target        = row.target;
        region_select = row.restart ? decoy : row.region;
        cur_region    = row.region;
        pause_rand    = row.rand_pause;
        credit_rand   = row.rand_credit;
        hold_credits  = row.withhold;
        reset_counter = 1'b1;                 // Leave finished from the last row
        @(negedge clk);
        reset_counter  = 1'b0;
        row_results    = 0;
        region_results = 0;
        row_active     = 1'b1;
        start          = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (row.withhold) begin
            wait_results(max_credits);
            repeat (120) @(negedge clk);      // Long enough for several more results
            if (row_results != max_credits) begin
                other_errors++;
                $display("Row %0d: %0d results went out with credits held", idx, row_results);
            end
            hold_credits = 1'b0;
        end
        if (row.restart) begin
            wait_results(3);
            reset_counter = 1'b1;
            region_select = row.region;       // Latched again while in init
            @(negedge clk);
            reset_counter = 1'b0;
            repeat (64) @(negedge clk);       // Engine queue drains below the restart burst
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        while (got < total_results) begin
            take_result(r);
            checked++;
            if (row.restart && got == 0 && r.message.msg[63 -: region_bits] == decoy) begin
                check_message(r.message, make_block(decoy, decoy_next), "message before restart");
                decoy_next++;
            end else begin
                check_message(r.message, make_block(row.region, got), "message");
                if (got == 0 && row.c0_known)
                    check_cipher(r.cipher, row.c0, "cipher of count 0");
                check_flag(r.match, got == row.match_count, "match flag");
                if (got == row.match_count)
                    check_cipher(r.cipher, row.target, "matching cipher");
                got++;
            end
        end
        while (!search_done)
            @(negedge clk);
        if (res_q.size() != 0) begin
            other_errors++;
            $display("Row %0d: results left over after the last count", idx);
        end
        pause_rand = 1'b0;
        while (total_sent != total_returned)  // Host gets every credit back
            @(negedge clk);
        row_active = 1'b0;
    endtask

    initial begin
        // All-zero key, target is the cipher of message 0
        stim[0] = '{key: 64'h0, region: 16'h0000, target: 64'h8CA64DE9C1B123A7,
                    rand_pause: 1'b0, rand_credit: 1'b0, withhold: 1'b0, restart: 1'b0,
                    match_count: 0, c0_known: 1'b1, c0: 64'h8CA64DE9C1B123A7};
        // Parity bits only, same subkeys as the zero key
        stim[1] = '{key: 64'h0101010101010101, region: 16'h0000, target: 64'h166B40B44ABA4BD6,
                    rand_pause: 1'b1, rand_credit: 1'b1, withhold: 1'b1, restart: 1'b0,
                    match_count: 1, c0_known: 1'b1, c0: 64'h8CA64DE9C1B123A7};
        // Target belongs to the all-ones message, never reached in this sweep
        stim[2] = '{key: 64'hFFFFFFFFFFFFFFFF, region: 16'hFFFF, target: 64'h7359B2163E4EDC58,
                    rand_pause: 1'b0, rand_credit: 1'b0, withhold: 1'b0, restart: 1'b1,
                    match_count: -1, c0_known: 1'b0, c0: 64'h0};
        rst_n         = 1'b0;
        start         = 1'b0;
        reset_counter = 1'b0;
        region_select = '0;
        key           = '0;
        target        = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(result_valid, 1'b0, "result_valid after reset");
        check_flag(search_done, 1'b0, "search_done after reset");
        for (int i = 0; i < num_rows; i++)
            run_row(i, stim[i]);
        $display("Checked %0d results, errors: message %0d, cipher %0d, flag %0d, other %0d",
                 checked, message_errors, cipher_errors, flag_errors, other_errors);
        if (message_errors + cipher_errors + flag_errors + other_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== verilog/des_pkg.sv ====
package des_pkg;

    typedef struct packed {
        logic [31:0] left;                      // L half, DES bits 1..32
        logic [31:0] right;                     // R half, DES bits 33..64
    } des_halves_t;

    // One 64-bit block, seen as search message or as cipher halves
    typedef union packed {
        logic [63:0] msg;                       // Region in the upper bits, count below
        des_halves_t halves;
    } des_block_u;

    typedef logic [63:0] des_key_t;             // Parity bits included, PC1 drops them

    // Tables use FIPS 46 numbering, bit 1 is the MSB
    localparam int ip [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};
    localparam int fp [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};
    localparam int e [48] = '{                  // Expansion of R to 48 bits
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21, 22, 23,
        24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};
    localparam int p [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};
    localparam int pc1 [56] = '{                // Key bits to C and D
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};
    localparam int pc2 [48] = '{                // C and D to the round subkey
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
        26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};
    localparam int shift_sched [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // S1..S8, each box row-major, four rows of sixteen nibbles
    localparam logic [0:7][0:63][3:0] sbox = {
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B};

    function automatic des_block_u initial_perm(input logic [63:0] x);
        des_block_u y;
        for (int i = 0; i < 64; i++)
            y.msg[63-i] = x[64-ip[i]];
        return y;
    endfunction

    function automatic logic [63:0] final_perm(input logic [63:0] x);
        logic [63:0] y;
        for (int i = 0; i < 64; i++)
            y[63-i] = x[64-fp[i]];
        return y;
    endfunction

    // Feistel function: expand, key mix, S-boxes, P
    function automatic logic [31:0] round_f(input logic [31:0] r, input logic [47:0] k);
        logic [47:0] x;
        logic [5:0]  b;
        logic [31:0] s;
        logic [31:0] f;
        for (int i = 0; i < 48; i++)
            x[47-i] = r[32-e[i]];
        x = x ^ k;
        for (int j = 0; j < 8; j++) begin
            b = x[47-6*j -: 6];
            s[31-4*j -: 4] = sbox[j][{b[5], b[0], b[4:1]}];  // Row from outer bits
        end
        for (int i = 0; i < 32; i++)
            f[31-i] = s[32-p[i]];
        return f;
    endfunction

    // Rotate C and D left by the schedule amount of round rnd (0..15)
    function automatic logic [55:0] key_rotate(input logic [55:0] cd, input logic [3:0] rnd);
        logic [27:0] c;
        logic [27:0] d;
        c = cd[55:28];
        d = cd[27:0];
        if (shift_sched[rnd] == 1) begin
            c = {c[26:0], c[27]};
            d = {d[26:0], d[27]};
        end else begin
            c = {c[25:0], c[27:26]};
            d = {d[25:0], d[27:26]};
        end
        return {c, d};
    endfunction

endpackage

// ==== verilog/des_round_engine.sv ====
module des_round_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  des_pkg::des_key_t   key,            // Fixed for the run
    input  logic [63:0]         target,         // Known ciphertext
    input  logic                host_pause,
    output logic                counter_pause,  // Back-pressure to the message counter
    input  des_pkg::des_block_u msg,
    input  logic                msg_valid,
    output search_pkg::result_t res,
    output logic                res_valid,      // High during the final round
    input  logic                fifo_full,      // Reporter cannot take res
    output logic                idle            // No message queued or in flight
);

    des_pkg::des_block_u q_mem [4];             // Message queue
    logic [1:0]          q_wr, q_rd;
    logic [2:0]          q_cnt, q_cnt_next;
    logic                queue_high;

    logic                busy;                  // A message is in the rounds
    logic [3:0]          rnd;                   // Round being computed, minus one
    des_pkg::des_block_u msg_reg;               // Plaintext of the message in flight
    des_pkg::des_block_u lr;                    // L and R of the current round
    logic [55:0]         cd;                    // C and D before this round's rotation
    logic [55:0]         cd_pc1, cd_next;
    logic [47:0]         subkey;
    logic [31:0]         l_next, r_next;
    logic [63:0]         cipher;
    logic                last_round, finish, pop;

    assign last_round = busy && (rnd == 4'd15);
    assign finish     = last_round && !fifo_full;             // Final round can retire
    assign pop        = (q_cnt != 3'd0) && (!busy || finish); // Back to back with retire
    assign q_cnt_next = q_cnt + {2'b00, msg_valid} - {2'b00, pop};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_wr       <= '0;
            q_rd       <= '0;
            q_cnt      <= '0;
            queue_high <= 1'b0;
        end else begin
            if (msg_valid)
                q_wr <= q_wr + 1'b1;
            if (pop)
                q_rd <= q_rd + 1'b1;
            q_cnt      <= q_cnt_next;
            queue_high <= (q_cnt_next >= 3'd2);  // Leaves room for the message after pause
        end
    end

    always_ff @(posedge clk) begin
        if (msg_valid)
            q_mem[q_wr] <= msg;
    end

    assign counter_pause = host_pause | queue_high;
    assign idle          = !busy && (q_cnt == 3'd0);

    // Key schedule and one Feistel round
    always_comb begin
        for (int i = 0; i < 56; i++)
            cd_pc1[55-i] = key[64-des_pkg::pc1[i]];  // Parity bits fall out here
        cd_next = des_pkg::key_rotate(cd, rnd);
        for (int i = 0; i < 48; i++)
            subkey[47-i] = cd_next[56-des_pkg::pc2[i]];
        l_next = lr.halves.right;
        r_next = lr.halves.left ^ des_pkg::round_f(lr.halves.right, subkey);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            rnd  <= '0;
        end else if (pop) begin
            busy <= 1'b1;
            rnd  <= '0;
        end else if (finish) begin
            busy <= 1'b0;
        end else if (busy && !last_round) begin
            rnd <= rnd + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            msg_reg <= q_mem[q_rd];
            lr      <= des_pkg::initial_perm(q_mem[q_rd].msg);
            cd      <= cd_pc1;
        end else if (busy && !last_round) begin
            lr.halves.left  <= l_next;
            lr.halves.right <= r_next;
            cd              <= cd_next;
        end
    end

    // Round 16 is not stored, halves swap before FP
    assign cipher      = des_pkg::final_perm({r_next, l_next});
    assign res.message = msg_reg;
    assign res.cipher  = cipher;
    assign res.match   = (cipher == target);
    assign res_valid   = last_round;

endmodule

// ==== verilog/des_search_top.sv ====
module des_search_top #(
    parameter int              region_bits = search_pkg::REGION_BITS_DEFAULT,
    parameter longint unsigned count_last  = search_pkg::COUNT_LAST_DEFAULT,
    parameter int              max_credits = search_pkg::CREDIT_MAX
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   pause,
    input  logic                   reset_counter,
    input  logic [region_bits-1:0] region_select,
    input  des_pkg::des_key_t      key,
    input  logic [63:0]            target,
    input  logic                   credit_return,
    output search_pkg::result_t    result,
    output logic                   result_valid,
    output logic                   search_done
);

    des_pkg::des_block_u msg;         // Counter to engine
    logic                msg_valid;
    logic                counter_pause;
    logic                gen_done;
    search_pkg::result_t res;         // Engine to reporter
    logic                res_valid;
    logic                fifo_full;
    logic                engine_idle;

    message_counter_partial #(
        .region_bits (region_bits),
        .count_last  (count_last)
    ) counter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .pause         (counter_pause),
        .reset_counter (reset_counter),
        .region_select (region_select),
        .counter       (msg),
        .valid         (msg_valid),
        .done          (gen_done)
    );

    des_round_engine engine_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .key           (key),
        .target        (target),
        .host_pause    (pause),
        .counter_pause (counter_pause),
        .msg           (msg),
        .msg_valid     (msg_valid),
        .res           (res),
        .res_valid     (res_valid),
        .fifo_full     (fifo_full),
        .idle          (engine_idle)
    );

    match_reporter #(
        .max_credits (max_credits)
    ) reporter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .res           (res),
        .res_valid     (res_valid),
        .fifo_full     (fifo_full),
        .gen_done      (gen_done),
        .engine_idle   (engine_idle),
        .credit_return (credit_return),
        .result        (result),
        .result_valid  (result_valid),
        .search_done   (search_done)
    );

endmodule

// ==== verilog/match_reporter.sv ====
module match_reporter #(
    parameter int max_credits = search_pkg::CREDIT_MAX
) (
    input  logic                clk,
    input  logic                rst_n,
    input  search_pkg::result_t res,
    input  logic                res_valid,
    output logic                fifo_full,
    input  logic                gen_done,       // Counter finished its region
    input  logic                engine_idle,
    input  logic                credit_return,  // Host frees one slot
    output search_pkg::result_t result,
    output logic                result_valid,
    output logic                search_done
);

    localparam int credit_w = $clog2(max_credits + 1);

    search_pkg::result_t fifo_mem [4];
    logic [1:0]          wr_ptr, rd_ptr;
    logic [2:0]          fifo_cnt;
    logic [credit_w-1:0] credits;               // Results the host can still accept
    logic                push, send, empty;

    assign fifo_full = (fifo_cnt == 3'd4);
    assign empty     = (fifo_cnt == 3'd0);
    assign push      = res_valid && !fifo_full;
    assign send      = !empty && (credits != '0);  // One result per credit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            credits  <= credit_w'(max_credits);
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (send)
                rd_ptr <= rd_ptr + 1'b1;
            fifo_cnt <= fifo_cnt + {2'b00, push} - {2'b00, send};
            credits  <= credits - credit_w'(send) + credit_w'(credit_return);  // Both may hit
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            fifo_mem[wr_ptr] <= res;
    end

    assign result       = fifo_mem[rd_ptr];
    assign result_valid = send;
    assign search_done  = gen_done && engine_idle && empty;  // Everything sent to the host

endmodule

// ==== verilog/message_counter_partial.sv ====
module message_counter_partial #(
    parameter int              region_bits = search_pkg::REGION_BITS_DEFAULT,
    parameter longint unsigned count_last  = search_pkg::COUNT_LAST_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,          // Begin a sweep of the selected region
    input  logic                     pause,          // Hold generation, host or engine back-pressure
    input  logic                     reset_counter,  // Abort and go back to init
    input  logic [region_bits-1:0]   region_select,
    output des_pkg::des_block_u      counter,        // Current message
    output logic                     valid,          // Message on counter is new this cycle
    output logic                     done            // Whole region generated
);

    localparam int count_w = 64 - region_bits;   // Running count takes the lower bits

    typedef enum logic [2:0] {
        init,
        first,
        working,
        paused,
        finished
    } state_t;

    state_t state, next_state;

    logic [count_w-1:0]     count_reg;
    logic [region_bits-1:0] region_reg;
    logic                   load_seed;     // Clear count, latch region
    logic                   load_counter;  // Step the count
    logic                   at_last;

    assign at_last = (count_reg == count_w'(count_last));

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= init;
        else
            state <= next_state;
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            init: begin
                if (start)
                    next_state = first;
            end
            first: begin
                next_state = working;          // Count 0 goes out here, pause not checked
            end
            working: begin
                // Last count ends the sweep before a pause can bring it back out again
                if (reset_counter)
                    next_state = init;
                else if (at_last)
                    next_state = finished;
                else if (pause)
                    next_state = paused;
            end
            paused: begin
                if (reset_counter)
                    next_state = init;
                else if (!pause)
                    next_state = working;
            end
            finished: begin
                if (reset_counter)
                    next_state = init;
            end
            default: next_state = init;
        endcase
    end

    // Outputs and datapath strobes
    always_comb begin
        load_seed    = 1'b0;
        load_counter = 1'b0;
        valid        = 1'b0;
        done         = 1'b0;
        case (state)
            init:     load_seed = 1'b1;
            first: begin
                valid        = 1'b1;           // All-zero count is a real message too
                load_counter = 1'b1;
            end
            working: begin
                valid        = 1'b1;
                load_counter = !at_last;       // Hold at the last count
            end
            finished: done = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_counter || load_seed)
            count_reg <= '0;
        else if (load_counter)
            count_reg <= count_reg + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (load_seed)
            region_reg <= region_select;       // Tracks the host until start
    end

    assign counter.msg = {region_reg, count_reg};

endmodule

// ==== verilog/search_pkg.sv ====
package search_pkg;

    // One search result as handed to the host
    typedef struct packed {
        des_pkg::des_block_u message;           // Plaintext that was tried
        logic [63:0]         cipher;            // Its ciphertext under the run key
        logic                match;             // Cipher equals the target
    } result_t;

    localparam int              REGION_BITS_DEFAULT = 16;  // Upper message bits from the host
    localparam longint unsigned COUNT_LAST_DEFAULT  = 32;  // Last count of a region sweep
    localparam int              CREDIT_MAX          = 4;   // Results the host can buffer

endpackage
